/* common/pinio_defines.svh */
/* Fixed board pin map and register map of the pin overlay.
   Pin roles must match the board wiring and are not per instance. */

`ifndef PINIO_DEFINES_SVH
`define PINIO_DEFINES_SVH

// Pin counts
`define PINIO_NUM_MIO 8
`define PINIO_NUM_DIO 8

// DIO roles, SPI pins double as JTAG
`define PINIO_DIO_SCK       0
`define PINIO_DIO_CSB       1
`define PINIO_DIO_SDI       2
`define PINIO_DIO_SDO       3
`define PINIO_DIO_USB_DP    4
`define PINIO_DIO_USB_DN    5
`define PINIO_DIO_USB_DP_PU 6
`define PINIO_DIO_USB_DN_PU 7

// MIO roles, JTAG strap is active high
`define PINIO_MIO_JTAG_EN   6
`define PINIO_MIO_JTAG_TRST 7

// APB register map, one 32-bit word each
`define PINIO_ADDR_W      8
`define PINIO_REG_MIO_OUT 8'h00
`define PINIO_REG_MIO_OE  8'h04
`define PINIO_REG_MIO_IN  8'h08
`define PINIO_REG_DIO_OUT 8'h0C
`define PINIO_REG_DIO_OE  8'h10
`define PINIO_REG_DIO_IN  8'h14
`define PINIO_REG_MIO_INV 8'h18
`define PINIO_REG_DIO_INV 8'h1C

`endif

/* common/pinio_pkg.sv */
/* Shared bus and pad types of the pin overlay.
   Widths follow the fixed pin counts in the defines header. */

`include "pinio_defines.svh"

package pinio_pkg;

  ////////////////////////////////////////////////////////////
  // APB
  ////////////////////////////////////////////////////////////

  // Requester side, one word per cycle
  typedef struct packed {
    logic [`PINIO_ADDR_W-1:0] paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [31:0]              pwdata;
  } apb_req_t;

  // Completer side, pready is tied high in this design
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////
  // Pads
  ////////////////////////////////////////////////////////////

  // Drive toward the pads, same layout at every stage
  typedef struct packed {
    logic [`PINIO_NUM_MIO-1:0] mio_out;
    logic [`PINIO_NUM_MIO-1:0] mio_oe;
    logic [`PINIO_NUM_DIO-1:0] dio_out;
    logic [`PINIO_NUM_DIO-1:0] dio_oe;
  } pad_drive_t;

  // Levels sensed at the pads
  typedef struct packed {
    logic [`PINIO_NUM_MIO-1:0] mio;
    logic [`PINIO_NUM_DIO-1:0] dio;
  } pad_sense_t;

  // Toward the TAP, tdo comes back on its own wire
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_req_t;

endpackage

/* src/pinio_regs.sv */
/* APB pin controller. pready is always 1, so there are no wait states.
   Pad inputs pass a two-flop synchronizer, so IN lags the pads by 2 clocks.
   Unmapped offsets and writes to IN registers return pslverr and read 0. */

`include "pinio_defines.svh"
`timescale 1ns/100ps

module pinio_regs
  import pinio_pkg::*;
(
  input  logic       clk_main_i,
  input  logic       arst_n_i,
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  output pad_drive_t core_drive_o,
  input  pad_sense_t core_sense_i
);

  logic [`PINIO_NUM_MIO-1:0] mio_out_q;
  logic [`PINIO_NUM_MIO-1:0] mio_oe_q;
  logic [`PINIO_NUM_MIO-1:0] mio_inv_q;
  logic [`PINIO_NUM_DIO-1:0] dio_out_q;
  logic [`PINIO_NUM_DIO-1:0] dio_oe_q;
  logic [`PINIO_NUM_DIO-1:0] dio_inv_q;

  pad_sense_t sense_meta_q;
  pad_sense_t sense_sync_q;

  logic        access;
  logic        reg_hit;
  logic        reg_ro;
  logic        bus_err;
  logic        wr_en;
  logic [31:0] rdata;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    reg_hit = 1'b1;
    reg_ro  = 1'b0;
    rdata   = '0;
    case (apb_req_i.paddr)
      `PINIO_REG_MIO_OUT: rdata = 32'(mio_out_q);
      `PINIO_REG_MIO_OE:  rdata = 32'(mio_oe_q);
      `PINIO_REG_MIO_IN: begin
        rdata  = 32'(sense_sync_q.mio ^ mio_inv_q);
        reg_ro = 1'b1;
      end
      `PINIO_REG_DIO_OUT: rdata = 32'(dio_out_q);
      `PINIO_REG_DIO_OE:  rdata = 32'(dio_oe_q);
      `PINIO_REG_DIO_IN: begin
        rdata  = 32'(sense_sync_q.dio ^ dio_inv_q);
        reg_ro = 1'b1;
      end
      `PINIO_REG_MIO_INV: rdata = 32'(mio_inv_q);
      `PINIO_REG_DIO_INV: rdata = 32'(dio_inv_q);
      default:            reg_hit = 1'b0;
    endcase
  end

  // Errored accesses change nothing
  assign bus_err = access & (~reg_hit | (apb_req_i.pwrite & reg_ro));
  assign wr_en   = access & apb_req_i.pwrite & ~bus_err;

  assign apb_rsp_o.prdata  = bus_err ? '0 : rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = bus_err;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mio_out_q <= '0;
      mio_oe_q  <= '0;
      mio_inv_q <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
      dio_inv_q <= '0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        `PINIO_REG_MIO_OUT: mio_out_q <= apb_req_i.pwdata[`PINIO_NUM_MIO-1:0];
        `PINIO_REG_MIO_OE:  mio_oe_q  <= apb_req_i.pwdata[`PINIO_NUM_MIO-1:0];
        `PINIO_REG_DIO_OUT: dio_out_q <= apb_req_i.pwdata[`PINIO_NUM_DIO-1:0];
        `PINIO_REG_DIO_OE:  dio_oe_q  <= apb_req_i.pwdata[`PINIO_NUM_DIO-1:0];
        `PINIO_REG_MIO_INV: mio_inv_q <= apb_req_i.pwdata[`PINIO_NUM_MIO-1:0];
        `PINIO_REG_DIO_INV: dio_inv_q <= apb_req_i.pwdata[`PINIO_NUM_DIO-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop synchronizer on all pad inputs
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sense_meta_q <= '0;
      sense_sync_q <= '0;
    end else begin
      sense_meta_q <= core_sense_i;
      sense_sync_q <= sense_meta_q;
    end
  end

  // Inversion applies to the output value and never to OE
  assign core_drive_o.mio_out = mio_out_q ^ mio_inv_q;
  assign core_drive_o.mio_oe  = mio_oe_q;
  assign core_drive_o.dio_out = dio_out_q ^ dio_inv_q;
  assign core_drive_o.dio_oe  = dio_oe_q;

  ////////////////////////////////////////////////////////////
  // APB protocol checks
  ////////////////////////////////////////////////////////////

  a_penable_needs_psel: assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i)
    $rose(apb_req_i.penable) |-> apb_req_i.psel
  );

  a_paddr_stable: assert property (
    @(posedge clk_main_i) disable iff (!arst_n_i)
    (apb_req_i.psel && !apb_req_i.penable) |=> $stable(apb_req_i.paddr)
  );

endmodule

/* overlay/usb_swap_mux.sv */
/* Undoes the USB D+/D- pin flip so the board always sees unflipped pins.
   The swap follows the core's D- pull-up OE. Purely combinational. */

`include "pinio_defines.svh"
`timescale 1ns/100ps

module usb_swap_mux
  import pinio_pkg::*;
(
  input  pad_drive_t core_drive_i,
  output pad_drive_t umux_drive_o,
  input  pad_sense_t umux_sense_i,
  output pad_sense_t core_sense_o
);

  logic undo_swap;

  // Core enables the D- pull-up only when it has flipped the pins
  assign undo_swap = core_drive_i.dio_oe[`PINIO_DIO_USB_DN_PU];

  always_comb begin
    umux_drive_o = core_drive_i;
    core_sense_o = umux_sense_i;
    if (undo_swap) begin
      // Data pins, both directions
      umux_drive_o.dio_out[`PINIO_DIO_USB_DP] = core_drive_i.dio_out[`PINIO_DIO_USB_DN];
      umux_drive_o.dio_out[`PINIO_DIO_USB_DN] = core_drive_i.dio_out[`PINIO_DIO_USB_DP];
      umux_drive_o.dio_oe[`PINIO_DIO_USB_DP]  = core_drive_i.dio_oe[`PINIO_DIO_USB_DN];
      umux_drive_o.dio_oe[`PINIO_DIO_USB_DN]  = core_drive_i.dio_oe[`PINIO_DIO_USB_DP];
      core_sense_o.dio[`PINIO_DIO_USB_DP]     = umux_sense_i.dio[`PINIO_DIO_USB_DN];
      core_sense_o.dio[`PINIO_DIO_USB_DN]     = umux_sense_i.dio[`PINIO_DIO_USB_DP];

      // Pull-ups, drive side only
      umux_drive_o.dio_out[`PINIO_DIO_USB_DP_PU] =
        core_drive_i.dio_out[`PINIO_DIO_USB_DN_PU];
      umux_drive_o.dio_out[`PINIO_DIO_USB_DN_PU] =
        core_drive_i.dio_out[`PINIO_DIO_USB_DP_PU];
      umux_drive_o.dio_oe[`PINIO_DIO_USB_DP_PU] =
        core_drive_i.dio_oe[`PINIO_DIO_USB_DN_PU];
      umux_drive_o.dio_oe[`PINIO_DIO_USB_DN_PU] =
        core_drive_i.dio_oe[`PINIO_DIO_USB_DP_PU];
    end
  end

endmodule

/* overlay/jtag_overlay_mux.sv */
/* JTAG overlay on the SPI pins, selected by the MIO6 strap (active high).
   While selected, the core sees fixed tie-offs on the six JTAG pins.
   Purely combinational, so TCK reaches the TAP with no clock. */

`include "pinio_defines.svh"
`timescale 1ns/100ps

module jtag_overlay_mux
  import pinio_pkg::*;
(
  input  pad_drive_t umux_drive_i,
  output pad_drive_t pad_drive_o,
  input  pad_sense_t pad_sense_i,
  output pad_sense_t umux_sense_o,
  output jtag_req_t  jtag_o,
  input  logic       jtag_tdo_i
);

  logic jtag_en;

  // Strap read straight from the pad
  assign jtag_en = pad_sense_i.mio[`PINIO_MIO_JTAG_EN];

  always_comb begin
    pad_drive_o  = umux_drive_i;
    umux_sense_o = pad_sense_i;
    jtag_o       = '0;

    if (jtag_en) begin
      ////////////////////////////////////////////////////////////
      // Pads to TAP
      ////////////////////////////////////////////////////////////
      jtag_o.tck    = pad_sense_i.dio[`PINIO_DIO_SCK];
      jtag_o.tms    = pad_sense_i.dio[`PINIO_DIO_CSB];
      jtag_o.tdi    = pad_sense_i.dio[`PINIO_DIO_SDI];
      jtag_o.trst_n = pad_sense_i.mio[`PINIO_MIO_JTAG_TRST];

      ////////////////////////////////////////////////////////////
      // Pad drive
      ////////////////////////////////////////////////////////////
      // TDO takes over the SDO pad
      pad_drive_o.dio_out[`PINIO_DIO_SDO] = jtag_tdo_i;
      pad_drive_o.dio_oe[`PINIO_DIO_SDO]  = 1'b1;

      // JTAG inputs must not be driven by the core
      pad_drive_o.dio_oe[`PINIO_DIO_SCK]       = 1'b0;
      pad_drive_o.dio_oe[`PINIO_DIO_CSB]       = 1'b0;
      pad_drive_o.dio_oe[`PINIO_DIO_SDI]       = 1'b0;
      pad_drive_o.mio_oe[`PINIO_MIO_JTAG_EN]   = 1'b0;
      pad_drive_o.mio_oe[`PINIO_MIO_JTAG_TRST] = 1'b0;

      ////////////////////////////////////////////////////////////
      // Core side tie-offs
      ////////////////////////////////////////////////////////////
      // CSB idles high so the SPI device stays deselected
      umux_sense_o.dio[`PINIO_DIO_SCK]       = 1'b0;
      umux_sense_o.dio[`PINIO_DIO_CSB]       = 1'b1;
      umux_sense_o.dio[`PINIO_DIO_SDI]       = 1'b0;
      umux_sense_o.dio[`PINIO_DIO_SDO]       = 1'b0;
      umux_sense_o.mio[`PINIO_MIO_JTAG_EN]   = 1'b0;
      umux_sense_o.mio[`PINIO_MIO_JTAG_TRST] = 1'b0;
    end
  end

endmodule

/* src/pinio_top.sv */
/* Pin overlay top. Drive path: controller, USB swap, JTAG overlay, pads.
   Pads are split into drive and sense ports, and tristates are resolved
   in the board wrapper. */

`include "pinio_defines.svh"
`timescale 1ns/100ps

module pinio_top
  import pinio_pkg::*;
(
  input  logic       clk_main_i,
  input  logic       arst_n_i,
  // APB
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  // Pads
  output pad_drive_t pad_drive_o,
  input  pad_sense_t pad_sense_i,
  // TAP
  output jtag_req_t  jtag_o,
  input  logic       jtag_tdo_i
);

  // Stage naming: core <- USB swap -> umux <- JTAG overlay -> pads
  pad_drive_t core_drive;
  pad_drive_t umux_drive;
  pad_sense_t core_sense;
  pad_sense_t umux_sense;

  ////////////////////////////////////////////////////////////
  // Pin controller
  ////////////////////////////////////////////////////////////

  pinio_regs u_regs (
    .clk_main_i   ( clk_main_i ),
    .arst_n_i     ( arst_n_i   ),
    .apb_req_i    ( apb_req_i  ),
    .apb_rsp_o    ( apb_rsp_o  ),
    .core_drive_o ( core_drive ),
    .core_sense_i ( core_sense )
  );

  ////////////////////////////////////////////////////////////
  // Overlays
  ////////////////////////////////////////////////////////////

  usb_swap_mux u_usb_swap (
    .core_drive_i ( core_drive ),
    .umux_drive_o ( umux_drive ),
    .umux_sense_i ( umux_sense ),
    .core_sense_o ( core_sense )
  );

  // Sits next to the pads so the strap is read before any swap
  jtag_overlay_mux u_jtag_overlay (
    .umux_drive_i ( umux_drive  ),
    .pad_drive_o  ( pad_drive_o ),
    .pad_sense_i  ( pad_sense_i ),
    .umux_sense_o ( umux_sense  ),
    .jtag_o       ( jtag_o      ),
    .jtag_tdo_i   ( jtag_tdo_i  )
  );

endmodule

/* bench/tb_pinio.sv */
/* Directed testbench for the pin overlay top. Inputs change on the falling
   edge, outputs are sampled 1 ns after it. Random data uses a fixed seed. */

`include "pinio_defines.svh"
`timescale 1ns/100ps

module tb_pinio
  import pinio_pkg::*;
();

  logic       clk_main;
  logic       arst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  pad_drive_t pad_drive;
  pad_sense_t pad_sense;
  jtag_req_t  jtag;
  logic       jtag_tdo;

  integer seed;
  int     cycles;
  int     pass_count;
  int     fail_count;
  int     test_errs;
  string  test_name;

  // Last values written predict the pads and the read-back
  logic [7:0] mio_out_v;
  logic [7:0] mio_oe_v;
  logic [7:0] mio_inv_v;
  logic [7:0] dio_out_v;
  logic [7:0] dio_oe_v;
  logic [7:0] dio_inv_v;

  pinio_top u_pinio_top (
    .clk_main_i  ( clk_main  ),
    .arst_n_i    ( arst_n    ),
    .apb_req_i   ( apb_req   ),
    .apb_rsp_o   ( apb_rsp   ),
    .pad_drive_o ( pad_drive ),
    .pad_sense_i ( pad_sense ),
    .jtag_o      ( jtag      ),
    .jtag_tdo_i  ( jtag_tdo  )
  );

  initial begin
    clk_main = 1'b0;
    forever #20 clk_main = ~clk_main;
  end

  always @(posedge clk_main) cycles++;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] rand8();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [7:0] swap_pair(input logic [7:0] v, input int a, input int b);
    logic [7:0] r;
    r    = v;
    r[a] = v[b];
    r[b] = v[a];
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("Test %s passed", test_name);
      pass_count++;
    end else begin
      $display("Test %s failed with %0d mismatches", test_name, test_errs);
      fail_count++;
    end
  endtask

  // One APB transfer with setup and access phases, sampled in the access phase
  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk_main);
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    @(negedge clk_main);
    apb_req.penable = 1'b1;
    #1;
    while (!apb_rsp.pready && waited < 16) begin
      @(negedge clk_main);
      #1;
      waited++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to offset %h never completed, pready stayed low", addr);
      $display("Something failed");
      $finish;
    end else begin
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(negedge clk_main);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] discard;
    apb_access(addr, 1'b1, data, discard, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, 32'h0, data, err);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic err;
    apb_write(addr, 32'(data), err);
    if (err !== 1'b0) report_mismatch("pslverr on write", 32'h0, 32'(err));
  endtask

  task automatic expect_reg(input string what, input logic [7:0] addr, input logic [7:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    if (data !== 32'(exp)) report_mismatch(what, 32'(exp), data);
    if (err !== 1'b0) report_mismatch({what, " pslverr"}, 32'h0, 32'(err));
  endtask

  task automatic set_pads(input pad_sense_t sense, input logic tdo);
    @(negedge clk_main);
    pad_sense = sense;
    jtag_tdo  = tdo;
    #1;
  endtask

  // Retries the read for up to 10 cycles until the synchronized value shows
  task automatic wait_in(input string what, input logic [7:0] addr, input logic [7:0] exp);
    logic [31:0] data;
    logic        err;
    int          start;
    data  = '1;
    start = cycles;
    while (data !== 32'(exp) && cycles - start < 10) begin
      apb_read(addr, data, err);
    end
    if (data !== 32'(exp)) report_mismatch(what, 32'(exp), data);
    if (err !== 1'b0) report_mismatch({what, " pslverr"}, 32'h0, 32'(err));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int i;
    begin_test("reset");
    for (i = 0; i < 8; i++) begin
      expect_reg("register after reset", 8'(i * 4), 8'h00);
    end
    if (pad_drive !== '0) report_mismatch("pad_drive_o", 32'h0, pad_drive);
    if (jtag.trst_n !== 1'b0) report_mismatch("jtag trst_n", 32'h0, 32'(jtag.trst_n));
    end_test();
  endtask

  task automatic test_gpio();
    pad_sense_t sense;
    begin_test("gpio_inversion");
    mio_out_v = rand8();
    mio_oe_v  = rand8();
    mio_inv_v = rand8();
    write_reg(`PINIO_REG_MIO_OUT, mio_out_v);
    write_reg(`PINIO_REG_MIO_OE, mio_oe_v);
    write_reg(`PINIO_REG_MIO_INV, mio_inv_v);
    // D- pull-up OE kept low so the USB swap stays idle
    dio_out_v = rand8();
    dio_oe_v  = rand8() & 8'h7F;
    dio_inv_v = rand8();
    write_reg(`PINIO_REG_DIO_OUT, dio_out_v);
    write_reg(`PINIO_REG_DIO_OE, dio_oe_v);
    write_reg(`PINIO_REG_DIO_INV, dio_inv_v);
    if (pad_drive !== {mio_out_v ^ mio_inv_v, mio_oe_v, dio_out_v ^ dio_inv_v, dio_oe_v})
      report_mismatch("pad_drive_o", {mio_out_v ^ mio_inv_v, mio_oe_v,
                      dio_out_v ^ dio_inv_v, dio_oe_v}, pad_drive);
    sense.mio = rand8() & 8'hBF;
    sense.dio = rand8();
    set_pads(sense, 1'b0);
    wait_in("MIO_IN", `PINIO_REG_MIO_IN, sense.mio ^ mio_inv_v);
    wait_in("DIO_IN", `PINIO_REG_DIO_IN, sense.dio ^ dio_inv_v);
    end_test();
  endtask

  task automatic test_bus_err();
    logic [31:0] data;
    logic        err;
    pad_sense_t  sense;
    begin_test("bus_errors");
    // MIO_IN made nonzero so its value would show on an errored write
    sense     = pad_sense;
    sense.mio = ~mio_inv_v & 8'hBF;
    set_pads(sense, 1'b0);
    wait_in("MIO_IN before errors", `PINIO_REG_MIO_IN, sense.mio ^ mio_inv_v);
    apb_read(8'h20, data, err);
    if (err !== 1'b1) report_mismatch("unmapped read pslverr", 32'h1, 32'(err));
    if (data !== 32'h0) report_mismatch("unmapped read data", 32'h0, data);
    apb_access(8'h24, 1'b1, 32'($random(seed)), data, err);
    if (err !== 1'b1) report_mismatch("unmapped write pslverr", 32'h1, 32'(err));
    if (data !== 32'h0) report_mismatch("unmapped write data", 32'h0, data);
    apb_access(`PINIO_REG_MIO_IN, 1'b1, 32'($random(seed)), data, err);
    if (err !== 1'b1) report_mismatch("MIO_IN write pslverr", 32'h1, 32'(err));
    if (data !== 32'h0) report_mismatch("MIO_IN write data", 32'h0, data);
    expect_reg("MIO_OUT kept", `PINIO_REG_MIO_OUT, mio_out_v);
    expect_reg("MIO_OE kept", `PINIO_REG_MIO_OE, mio_oe_v);
    expect_reg("MIO_INV kept", `PINIO_REG_MIO_INV, mio_inv_v);
    expect_reg("DIO_OUT kept", `PINIO_REG_DIO_OUT, dio_out_v);
    expect_reg("DIO_OE kept", `PINIO_REG_DIO_OE, dio_oe_v);
    expect_reg("DIO_INV kept", `PINIO_REG_DIO_INV, dio_inv_v);
    end_test();
  endtask

  task automatic test_usb();
    pad_sense_t sense;
    logic [7:0] exp_out;
    logic [7:0] exp_oe;
    begin_test("usb_flip");
    dio_inv_v = 8'h00;
    // Pair members differ so an exchange is visible
    dio_out_v = (rand8() & 8'h0F) | 8'h50;
    dio_oe_v  = (rand8() & 8'h0F) | 8'h90;
    write_reg(`PINIO_REG_DIO_INV, dio_inv_v);
    write_reg(`PINIO_REG_DIO_OUT, dio_out_v);
    write_reg(`PINIO_REG_DIO_OE, dio_oe_v);
    exp_out = swap_pair(swap_pair(dio_out_v, `PINIO_DIO_USB_DP, `PINIO_DIO_USB_DN),
                        `PINIO_DIO_USB_DP_PU, `PINIO_DIO_USB_DN_PU);
    exp_oe  = swap_pair(swap_pair(dio_oe_v, `PINIO_DIO_USB_DP, `PINIO_DIO_USB_DN),
                        `PINIO_DIO_USB_DP_PU, `PINIO_DIO_USB_DN_PU);
    if (pad_drive.dio_out !== exp_out) report_mismatch("swapped dio_out", 32'(exp_out),
                                                       32'(pad_drive.dio_out));
    if (pad_drive.dio_oe !== exp_oe) report_mismatch("swapped dio_oe", 32'(exp_oe),
                                                     32'(pad_drive.dio_oe));
    sense.mio = rand8() & 8'hBF;
    sense.dio = (rand8() & 8'hCF) | 8'h10;
    set_pads(sense, 1'b0);
    wait_in("swapped DIO_IN", `PINIO_REG_DIO_IN,
            swap_pair(sense.dio, `PINIO_DIO_USB_DP, `PINIO_DIO_USB_DN));
    // Swap off again
    dio_oe_v = dio_oe_v & 8'h7F;
    write_reg(`PINIO_REG_DIO_OE, dio_oe_v);
    if (pad_drive.dio_out !== dio_out_v) report_mismatch("plain dio_out", 32'(dio_out_v),
                                                         32'(pad_drive.dio_out));
    if (pad_drive.dio_oe !== dio_oe_v) report_mismatch("plain dio_oe", 32'(dio_oe_v),
                                                       32'(pad_drive.dio_oe));
    wait_in("plain DIO_IN", `PINIO_REG_DIO_IN, sense.dio);
    end_test();
  endtask

  task automatic test_jtag();
    pad_sense_t sense;
    jtag_req_t  exp_jtag;
    logic       tdo;
    int         round;
    begin_test("jtag_overlay");
    mio_inv_v = 8'h00;
    mio_oe_v  = 8'hFF;
    // Core leaves SDO undriven so the overlay's own OE shows
    dio_oe_v  = 8'h77;
    mio_out_v = rand8();
    dio_out_v = rand8();
    write_reg(`PINIO_REG_MIO_INV, mio_inv_v);
    write_reg(`PINIO_REG_MIO_OE, mio_oe_v);
    write_reg(`PINIO_REG_DIO_OE, dio_oe_v);
    write_reg(`PINIO_REG_MIO_OUT, mio_out_v);
    write_reg(`PINIO_REG_DIO_OUT, dio_out_v);
    for (round = 0; round < 3; round++) begin
      sense.mio = rand8() | 8'h40;
      sense.dio = rand8();
      // TDO takes both levels and differs from the core's SDO value in rounds 0 and 2
      tdo       = ~(dio_out_v[`PINIO_DIO_SDO] ^ round[0]);
      set_pads(sense, tdo);
      exp_jtag.tck    = sense.dio[`PINIO_DIO_SCK];
      exp_jtag.tms    = sense.dio[`PINIO_DIO_CSB];
      exp_jtag.trst_n = sense.mio[`PINIO_MIO_JTAG_TRST];
      exp_jtag.tdi    = sense.dio[`PINIO_DIO_SDI];
      if (jtag !== exp_jtag) report_mismatch("jtag_o", 32'(exp_jtag), 32'(jtag));
      if (pad_drive.dio_out[`PINIO_DIO_SDO] !== tdo)
        report_mismatch("SDO pad value", 32'(tdo), 32'(pad_drive.dio_out[`PINIO_DIO_SDO]));
      if (pad_drive.dio_oe[3:0] !== 4'b1000)
        report_mismatch("SPI pad oe", 32'h8, 32'(pad_drive.dio_oe[3:0]));
      if (pad_drive.mio_oe[7:6] !== 2'b00)
        report_mismatch("MIO6/7 pad oe", 32'h0, 32'(pad_drive.mio_oe[7:6]));
      // CSB ties off high and the other JTAG pins low
      wait_in("DIO_IN tie-off", `PINIO_REG_DIO_IN, {sense.dio[7:4], 4'b0010});
      wait_in("MIO_IN tie-off", `PINIO_REG_MIO_IN, {2'b00, sense.mio[5:0]});
    end
    sense.mio = rand8() & 8'hBF;
    sense.dio = rand8();
    set_pads(sense, 1'b1);
    if (jtag !== '0) report_mismatch("jtag_o released", 32'h0, 32'(jtag));
    if (pad_drive !== {mio_out_v, mio_oe_v, dio_out_v, dio_oe_v})
      report_mismatch("pad_drive_o released", {mio_out_v, mio_oe_v, dio_out_v, dio_oe_v},
                      pad_drive);
    wait_in("DIO_IN released", `PINIO_REG_DIO_IN, sense.dio);
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h29df;
    pass_count = 0;
    fail_count = 0;
    arst_n     = 1'b0;
    apb_req    = '0;
    pad_sense  = '0;
    jtag_tdo   = 1'b0;
    repeat (2) @(posedge clk_main);
    @(negedge clk_main);
    arst_n = 1'b1;
    test_reset();
    test_gpio();
    test_bus_err();
    test_usb();
    test_jtag();
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/pinio_pkg.sv
src/pinio_regs.sv
overlay/usb_swap_mux.sv
overlay/jtag_overlay_mux.sv
src/pinio_top.sv
bench/tb_pinio.sv

/* run.sh */
#!/bin/sh
# Builds the pin overlay testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_pinio -Mdir obj_dir -o sim_pinio -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_pinio)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi
